/* filelist.f */
+incdir+include
hdl/digit_pkg.sv
hdl/weight_rom.sv
hdl/dense_layer.sv
hdl/mlp.sv
hdl/argmax_digit.sv
hdl/digit_classifier.sv
tb/digit_classifier_tb.sv

/* hdl/argmax_digit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "digit_settings.svh"

module argmax_digit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     go,
    input  logic [`N_OUT*`ACT_W-1:0] input_nums,
    output digit_pkg::digit_t        predicted,
    output logic                     done
);

    logic              busy;
    logic              take;
    digit_pkg::digit_t scan_idx;
    digit_pkg::act_t   candidate;
    digit_pkg::act_t   best_val;

    assign candidate = input_nums[scan_idx*`ACT_W +: `ACT_W];

    // Strictly greater only, so ties keep the lower index
    assign take = busy && ((scan_idx == '0) || (candidate > best_val));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            scan_idx  <= '0;
            predicted <= '0;
        end else begin
            done <= 1'b0;
            if (go) begin
                busy     <= 1'b1;
                scan_idx <= '0;
            end else if (busy) begin
                if (take) begin
                    predicted <= scan_idx;
                end
                if (scan_idx == 4'(`N_OUT - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    scan_idx <= scan_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            best_val <= candidate;
        end
    end

    digit_in_range: assert property (@(posedge clk) disable iff (reset) predicted < `N_OUT);

endmodule

`default_nettype wire

/* hdl/dense_layer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "digit_settings.svh"

module dense_layer #(
    parameter type in_t      = digit_pkg::pixel_t,
    parameter int  N_IN      = `N_PIXELS,
    parameter int  N_NEURONS = `N_HIDDEN,
    parameter int  LAYER     = 0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          go,
    input  logic [N_IN*$bits(in_t)-1:0]   in_vec,
    output logic [N_NEURONS*`ACT_W-1:0]   out_vec,
    output logic                          done
);

    localparam int IN_W         = $bits(in_t);
    localparam int IN_IDX_W     = (N_IN > 1) ? $clog2(N_IN) : 1;
    localparam int NEURON_IDX_W = (N_NEURONS > 1) ? $clog2(N_NEURONS) : 1;
    localparam int ACT_MAX      = (1 << `ACT_W) - 1;

    logic                    busy;
    logic [IN_IDX_W-1:0]     in_idx;
    logic [NEURON_IDX_W-1:0] neuron_idx;
    logic                    last_input;
    logic                    last_neuron;
    in_t                     in_elem;
    logic signed [IN_W:0]    in_ext;
    digit_pkg::weight_t      weight;
    digit_pkg::acc_t         acc;
    digit_pkg::acc_t         product;
    digit_pkg::acc_t         acc_next;

    // ReLU, then shift, then clip to the activation width
    function automatic digit_pkg::act_t activate(input digit_pkg::acc_t sum);
        digit_pkg::acc_t shifted;
        if (sum < 0) begin
            return '0;
        end
        shifted = sum >>> `ACT_SHIFT;
        if (shifted > ACT_MAX) begin
            return '1;
        end
        return shifted[`ACT_W-1:0];
    endfunction

    weight_rom weight_rom_inst (
        .layer     (LAYER != 0),
        .neuron    (4'(neuron_idx)),
        .input_idx (5'(in_idx)),
        .weight    (weight)
    );

    assign in_elem     = in_vec[in_idx*IN_W +: IN_W];
    assign in_ext      = signed'({1'b0, in_elem});
    assign product     = in_ext * weight;
    assign last_input  = (in_idx == IN_IDX_W'(N_IN - 1));
    assign last_neuron = (neuron_idx == NEURON_IDX_W'(N_NEURONS - 1));

    // First input of each neuron starts a fresh sum
    assign acc_next = ((in_idx == '0) ? '0 : acc) + product;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            in_idx     <= '0;
            neuron_idx <= '0;
        end else begin
            done <= 1'b0;
            if (go) begin
                busy       <= 1'b1;
                in_idx     <= '0;
                neuron_idx <= '0;
            end else if (busy) begin
                if (last_input) begin
                    in_idx <= '0;
                    if (last_neuron) begin
                        busy       <= 1'b0;
                        done       <= 1'b1;
                        neuron_idx <= '0;
                    end else begin
                        neuron_idx <= neuron_idx + 1'b1;
                    end
                end else begin
                    in_idx <= in_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            acc <= acc_next;
            if (last_input) begin
                out_vec[neuron_idx*`ACT_W +: `ACT_W] <= activate(acc_next);
            end
        end
    end

    // Upstream must wait for done before the next go
    go_while_busy: assert property (@(posedge clk) disable iff (reset) go |-> !busy);

    index_range: assert property (@(posedge clk) disable iff (reset)
        busy |-> (in_idx < N_IN) && (neuron_idx < N_NEURONS));

endmodule

`default_nettype wire

/* hdl/digit_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

`include "digit_settings.svh"

module digit_classifier (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          en,
    input  logic [`N_PIXELS*`PIXEL_W-1:0] averaged_pixels,
    output digit_pkg::digit_t             predict_digit,
    output logic                          done
);

    typedef enum logic [2:0] {
        ST_RESET,
        ST_IDLE,
        ST_MLP_START,
        ST_MLP_WAIT,
        ST_ARGMAX_START,
        ST_ARGMAX_WAIT,
        ST_DIGIT_OUT
    } state_t;

    state_t                      state;
    state_t                      next_state;
    logic                        mlp_go;
    logic                        mlp_done;
    logic                        mlp_done_seen;
    logic                        argmax_go;
    logic                        argmax_done;
    logic                        argmax_done_seen;
    logic [`N_OUT*`ACT_W-1:0]    output_activations;
    digit_pkg::digit_t           predicted;

    mlp mlp_inst (
        .clk                (clk),
        .reset              (reset),
        .mlp_go             (mlp_go),
        .averaged_pixels    (averaged_pixels),
        .output_activations (output_activations),
        .mlp_done           (mlp_done)
    );

    argmax_digit argmax_digit_inst (
        .clk        (clk),
        .reset      (reset),
        .go         (argmax_go),
        .input_nums (output_activations),
        .predicted  (predicted),
        .done       (argmax_done)
    );

    // Freezes with en low
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
        end else if (en) begin
            state <= next_state;
        end
    end

    // Datapath keeps running while frozen, so remember a done pulse we could not act on
    always_ff @(posedge clk) begin
        if (reset) begin
            mlp_done_seen    <= 1'b0;
            argmax_done_seen <= 1'b0;
        end else begin
            if (state == ST_MLP_START) begin
                mlp_done_seen <= 1'b0;
            end else if (mlp_done) begin
                mlp_done_seen <= 1'b1;
            end
            if (state == ST_ARGMAX_START) begin
                argmax_done_seen <= 1'b0;
            end else if (argmax_done) begin
                argmax_done_seen <= 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            ST_RESET:        next_state = ST_IDLE;
            ST_IDLE:         next_state = start ? ST_MLP_START : ST_IDLE;
            ST_MLP_START:    next_state = ST_MLP_WAIT;
            ST_MLP_WAIT:     next_state = (mlp_done || mlp_done_seen) ? ST_ARGMAX_START
                                                                      : ST_MLP_WAIT;
            ST_ARGMAX_START: next_state = ST_ARGMAX_WAIT;
            ST_ARGMAX_WAIT:  next_state = (argmax_done || argmax_done_seen) ? ST_DIGIT_OUT
                                                                            : ST_ARGMAX_WAIT;
            ST_DIGIT_OUT:    next_state = ST_IDLE;
            default:         next_state = ST_RESET;
        endcase
    end

    // Digit is captured on the edge into ST_DIGIT_OUT
    always_ff @(posedge clk) begin
        if (reset) begin
            predict_digit <= '0;
        end else if (en && (state == ST_ARGMAX_WAIT) && (next_state == ST_DIGIT_OUT)) begin
            predict_digit <= predicted;
        end
    end

    // Strobes fire only on a cycle the controller advances, so each stays one cycle wide
    assign mlp_go    = en && (state == ST_MLP_START);
    assign argmax_go = en && (state == ST_ARGMAX_START);
    assign done      = en && (state == ST_DIGIT_OUT);

endmodule

`default_nettype wire

/* hdl/digit_pkg.sv */
`default_nettype none

`include "digit_settings.svh"

package digit_pkg;

    // Averaged input pixel
    typedef logic [`PIXEL_W-1:0] pixel_t;

    // Neuron output after ReLU, shift and saturation
    typedef logic [`ACT_W-1:0] act_t;

    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic signed [`WEIGHT_W-1:0] weight_t;

    // Predicted class, 0 to 9
    typedef logic [3:0] digit_t;

endpackage

`default_nettype wire

/* hdl/mlp.sv */
`timescale 1ns/100ps
`default_nettype none

`include "digit_settings.svh"

module mlp (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          mlp_go,
    input  logic [`N_PIXELS*`PIXEL_W-1:0] averaged_pixels,
    output logic [`N_OUT*`ACT_W-1:0]      output_activations,
    output logic                          mlp_done
);

    // Held in the hidden layer output registers until the next image
    logic [`N_HIDDEN*`ACT_W-1:0] hidden_activations;
    logic                        hidden_done;

    dense_layer #(
        .in_t      (digit_pkg::pixel_t),
        .N_IN      (`N_PIXELS),
        .N_NEURONS (`N_HIDDEN),
        .LAYER     (0)
    ) hidden_layer_inst (
        .clk     (clk),
        .reset   (reset),
        .go      (mlp_go),
        .in_vec  (averaged_pixels),
        .out_vec (hidden_activations),
        .done    (hidden_done)
    );

    // Output layer starts the cycle the hidden layer finishes
    dense_layer #(
        .in_t      (digit_pkg::act_t),
        .N_IN      (`N_HIDDEN),
        .N_NEURONS (`N_OUT),
        .LAYER     (1)
    ) output_layer_inst (
        .clk     (clk),
        .reset   (reset),
        .go      (hidden_done),
        .in_vec  (hidden_activations),
        .out_vec (output_activations),
        .done    (mlp_done)
    );

endmodule

`default_nettype wire

/* hdl/weight_rom.sv */
`timescale 1ns/100ps
`default_nettype none

`include "digit_settings.svh"

module weight_rom (
    input  logic               layer,
    input  logic [3:0]         neuron,
    input  logic [4:0]         input_idx,
    output digit_pkg::weight_t weight
);

    logic [7:0]        index_sum;
    logic [3:0]        residue;
    logic signed [4:0] centred;

    // Largest sum of 7*15 + 3*31 + 5 still fits in 8 bits
    assign index_sum = 8'(neuron) * 8'd7 + 8'(input_idx) * 8'd3 + (layer ? 8'd5 : 8'd0);

    assign residue = 4'(index_sum % 8'd9);

    // Shift 0..8 down to -4..+4
    assign centred = signed'({1'b0, residue}) - 5'sd4;

    assign weight = centred[`WEIGHT_W-1:0];

endmodule

`default_nettype wire

/* include/digit_settings.svh */
`ifndef DIGIT_SETTINGS_SVH
`define DIGIT_SETTINGS_SVH

// Network shape
`define N_PIXELS 16
`define N_HIDDEN 8
`define N_OUT 10

// Data widths
`define PIXEL_W 8
`define ACT_W 16
`define ACC_W 32
`define WEIGHT_W 4

// Right shift after ReLU keeps activations in range between layers
`define ACT_SHIFT 4

`endif

/* tb/digit_classifier_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "digit_settings.svh"

module digit_classifier_tb;

    localparam int N_ROWS         = 8;
    localparam int PIX_W          = `PIXEL_W;
    localparam int IMG_W          = `N_PIXELS * `PIXEL_W;
    localparam int ACT_MAX        = (1 << `ACT_W) - 1;
    localparam int TIMEOUT        = 1000;
    localparam int HOLD_CYCLES    = 5;
    localparam int EXTRA_AT       = 20;
    // Both layers, the arg-max scan and their done cycles
    localparam int UNSTALLED      = (`N_PIXELS * `N_HIDDEN + 1) + (`N_HIDDEN * `N_OUT + 1)
                                    + `N_OUT + 1;
    // Idle to MLP start, MLP wait to arg-max start, arg-max wait to digit out
    localparam int CONTROL_CYCLES = 3;
    localparam int LATENCY        = UNSTALLED + CONTROL_CYCLES;

    logic              clk;
    logic              reset;
    logic              start;
    logic              en;
    logic [IMG_W-1:0]  averaged_pixels;
    digit_pkg::digit_t predict_digit;
    logic              done;

    logic [IMG_W-1:0] image_tab [N_ROWS];
    int               stall_at_tab [N_ROWS];
    int               stall_len_tab [N_ROWS];
    bit               extra_tab [N_ROWS];
    int               expect_tab [N_ROWS];

    integer seed;
    int     last_digit;

    digit_classifier digit_classifier_inst (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .en              (en),
        .averaged_pixels (averaged_pixels),
        .predict_digit   (predict_digit),
        .done            (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input logic signed [63:0] actual, input logic signed [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t, %s, got %0d, expected %0d",
                                $time, what, actual, expected));
        end
    endtask

    function automatic int weight_of(input int layer, input int neuron, input int idx);
        return ((7 * neuron + 3 * idx + 5 * layer) % 9) - 4;
    endfunction

    function automatic int activation(input int sum);
        int shifted;
        if (sum < 0) begin
            return 0;
        end
        shifted = sum >> `ACT_SHIFT;
        return (shifted > ACT_MAX) ? ACT_MAX : shifted;
    endfunction

    // Expected digit of one image with ties to the lowest index
    function automatic int predict_model(input logic [IMG_W-1:0] img);
        int hidden [`N_HIDDEN];
        int sum;
        int best;
        int best_idx;
        for (int n = 0; n < `N_HIDDEN; n++) begin
            sum = 0;
            for (int i = 0; i < `N_PIXELS; i++) begin
                sum += weight_of(0, n, i) * int'(img[i*PIX_W +: PIX_W]);
            end
            hidden[n] = activation(sum);
        end
        best = -1;
        best_idx = 0;
        for (int m = 0; m < `N_OUT; m++) begin
            sum = 0;
            for (int j = 0; j < `N_HIDDEN; j++) begin
                sum += weight_of(1, m, j) * hidden[j];
            end
            if (activation(sum) > best) begin
                best = activation(sum);
                best_idx = m;
            end
        end
        return best_idx;
    endfunction

    function automatic bit stalled(input int r, input int cycle);
        return (cycle >= stall_at_tab[r]) && (cycle < stall_at_tab[r] + stall_len_tab[r]);
    endfunction

    task automatic fill_table();
        for (int r = 0; r < N_ROWS; r++) begin
            stall_at_tab[r] = 0;
            stall_len_tab[r] = 0;
            extra_tab[r] = 1'b0;
            for (int i = 0; i < `N_PIXELS; i++) begin
                case (r)
                    0:       image_tab[r][i*PIX_W +: PIX_W] = '0;
                    1:       image_tab[r][i*PIX_W +: PIX_W] = '1;
                    2:       image_tab[r][i*PIX_W +: PIX_W] = PIX_W'(i * 16);
                    default: image_tab[r][i*PIX_W +: PIX_W] = PIX_W'($random(seed));
                endcase
            end
        end
        // Long freeze inside the MLP wait, then one around the hand-over to arg-max
        stall_at_tab[4] = 5;
        stall_len_tab[4] = 250;
        stall_at_tab[6] = 200;
        stall_len_tab[6] = 40;
        extra_tab[2] = 1'b1;
        extra_tab[5] = 1'b1;
        extra_tab[6] = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            expect_tab[r] = predict_model(image_tab[r]);
        end
    endtask

    task automatic run_row(input int r);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        @(posedge clk);
        averaged_pixels <= image_tab[r];
        start <= 1'b1;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            if (!en) begin
                check(done, 0, "done while en low");
            end
            if (done) begin
                seen = 1'b1;
            end else begin
                check(predict_digit, last_digit, "digit changed before done");
                @(posedge clk);
                cycles++;
                en <= !stalled(r, cycles);
                start <= extra_tab[r] && (cycles == EXTRA_AT);
            end
        end
        if (!seen) begin
            abort_run($sformatf("done never arrived for table row %0d", r));
        end
        check(predict_digit, expect_tab[r], $sformatf("digit for row %0d", r));
        if (stall_len_tab[r] == 0) begin
            check(cycles, LATENCY, "unstalled latency");
        end else begin
            check(cycles > LATENCY, 1, "stalled latency above unstalled");
        end
        // One cycle wide, then the digit holds
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check(done, 0, "done after its one cycle");
            check(predict_digit, expect_tab[r], "digit held after done");
        end
        last_digit = expect_tab[r];
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        en = 1'b1;
        averaged_pixels = '0;
        seed = 30;
        last_digit = 0;
        fill_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check(done, 0, "done after reset");
            check(predict_digit, 0, "digit after reset");
        end
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
